//--- include/exec_defs.svh
//////////////////////////////////////////////////////////////////////
// widths, depths and multiplier latency of the execute slice
// included by the package and by every module that sizes a port or array
//////////////////////////////////////////////////////////////////////
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// datapath and index widths
`define DATA_W      16
`define PREG_W      6
`define ROB_W       6

// data memory, low address bits only
`define DMEM_AW     8

// storage depths
`define RF_DEPTH    (1 << `PREG_W)
`define DMEM_DEPTH  (1 << `DMEM_AW)

// radix-16 multiplier, one nibble of b per step
`define MULT_STEPS  4

`endif

//--- logic/exec_pkg.sv
//////////////////////////////////////////////////////////////////////
// types passed between the execution units, EX/WB register and writeback
//////////////////////////////////////////////////////////////////////
`include "exec_defs.svh"

package exec_pkg;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_shl, alu_shr, alu_pass_b
    } alu_op_e;

    // issued operation for alu1, alu2 or mult
    typedef struct packed {
        logic               valid;
        alu_op_e            op;
        logic [`DATA_W-1:0] src_a;
        logic [`DATA_W-1:0] src_b;
        logic [`PREG_W-1:0] dst_preg;
        logic [`ROB_W-1:0]  rob_idx;
        logic               reg_wrt;
    } exec_req_t;

    // load/store request to the address unit
    typedef struct packed {
        logic               valid;
        logic               is_store;
        logic [`DATA_W-1:0] base;
        logic [`DATA_W-1:0] offset;
        logic [`DATA_W-1:0] store_data;
        logic [`PREG_W-1:0] dst_preg;
        logic [`ROB_W-1:0]  rob_idx;
    } mem_req_t;

    typedef struct packed {
        logic               done_vld;
        logic [`ROB_W-1:0]  done_idx;
        logic               reg_wrt;
        logic [`PREG_W-1:0] phy_addr;
        logic [`DATA_W-1:0] data;
    } unit_result_t;

    typedef struct packed {
        logic               done_vld;
        logic [`ROB_W-1:0]  done_idx;
        logic               mem_rd;
        logic               mem_wrt;
        logic [`PREG_W-1:0] phy_addr;
        logic [`DATA_W-1:0] addr;
        logic [`DATA_W-1:0] store_data;
    } mem_op_t;

    // full EX/WB word
    typedef struct packed {
        unit_result_t alu1;
        unit_result_t alu2;
        unit_result_t mult;
        mem_op_t      ldst;
    } ex_wb_t;

    // completion report towards the ROB
    typedef struct packed {
        logic              alu1_done_vld;
        logic [`ROB_W-1:0] alu1_done_idx;
        logic              alu2_done_vld;
        logic [`ROB_W-1:0] alu2_done_idx;
        logic              mult_done_vld;
        logic [`ROB_W-1:0] mult_done_idx;
        logic              ldst_done_vld;
        logic [`ROB_W-1:0] ldst_done_idx;
    } wb_done_t;

endpackage

//--- logic/alu_unit.sv
//////////////////////////////////////////////////////////////////////
// single-cycle integer ALU, one result record per issued operation
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_defs.svh"

module alu_unit
    import exec_pkg::*;
(
    input  exec_req_t    req,
    output unit_result_t res
);

    logic [`DATA_W-1:0] result;
    logic [3:0]         shamt;

    // shifts take only the low nibble of b
    assign shamt = req.src_b[3:0];

    always_comb begin
        case (req.op)
            alu_add: begin
                result = req.src_a + req.src_b;
            end
            alu_sub: begin
                result = req.src_a - req.src_b;
            end
            alu_and: begin
                result = req.src_a & req.src_b;
            end
            alu_or: begin
                result = req.src_a | req.src_b;
            end
            alu_xor: begin
                result = req.src_a ^ req.src_b;
            end
            alu_shl: begin
                result = req.src_a << shamt;
            end
            alu_shr: begin
                result = req.src_a >> shamt;
            end
            default: begin
                result = req.src_b;
            end
        endcase
    end

    // completes in the same cycle it is issued
    assign res.done_vld = req.valid;
    assign res.done_idx = req.rob_idx;
    assign res.reg_wrt  = req.reg_wrt;
    assign res.phy_addr = req.dst_preg;
    assign res.data     = result;

endmodule

//--- logic/mult_unit.sv
//////////////////////////////////////////////////////////////////////
// iterative radix-16 multiplier, low 16 bits of the product
// accepts a new request only while mult_idle is high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_defs.svh"

module mult_unit
    import exec_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         stall,
    input  exec_req_t    req,
    output unit_result_t res,
    output logic         mult_idle
);

    localparam int CNT_W = $clog2(`MULT_STEPS);

    logic               busy;
    logic               res_vld;
    logic [CNT_W-1:0]   step_cnt;
    logic               accept;
    logic               step_en;
    logic [`DATA_W-1:0] a_q;
    logic [`DATA_W-1:0] b_q;
    logic [`DATA_W-1:0] acc;
    logic [`DATA_W-1:0] step_a;
    logic [`DATA_W-1:0] step_b;
    logic [`DATA_W-1:0] pp;
    logic [`PREG_W-1:0] dst_q;
    logic [`ROB_W-1:0]  rob_q;
    logic               reg_wrt_q;

    assign accept  = !busy && req.valid && !stall;
    assign step_en = busy && !res_vld && !stall;

    // first nibble is taken straight from the request on accept
    assign step_a = busy ? a_q : req.src_a;
    assign step_b = busy ? b_q : req.src_b;
    assign pp     = step_a * {{(`DATA_W-4){1'b0}}, step_b[3:0]};

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            res_vld  <= 1'b0;
            step_cnt <= '0;
        end else if (accept) begin
            busy     <= 1'b1;
            step_cnt <= CNT_W'(1);
        end else if (res_vld && !stall) begin
            // result taken by EX/WB this edge
            busy    <= 1'b0;
            res_vld <= 1'b0;
        end else if (step_en) begin
            step_cnt <= step_cnt + 1'b1;
            if (step_cnt == CNT_W'(`MULT_STEPS - 1)) begin
                res_vld <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // operands and accumulator
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q       <= req.src_a << 4;
            b_q       <= req.src_b >> 4;
            acc       <= pp;
            dst_q     <= req.dst_preg;
            rob_q     <= req.rob_idx;
            reg_wrt_q <= req.reg_wrt;
        end else if (step_en) begin
            a_q <= a_q << 4;
            b_q <= b_q >> 4;
            acc <= acc + pp;
        end
    end

    assign res.done_vld = res_vld;
    assign res.done_idx = rob_q;
    assign res.reg_wrt  = reg_wrt_q;
    assign res.phy_addr = dst_q;
    assign res.data     = acc;
    assign mult_idle    = !busy;

endmodule

//--- logic/addr_unit.sv
//////////////////////////////////////////////////////////////////////
// load/store address adder, forms the memory operation for writeback
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_defs.svh"

module addr_unit
    import exec_pkg::*;
(
    input  mem_req_t req,
    output mem_op_t  op
);

    logic [`DATA_W-1:0] eff_addr;

    // full width sum, memory decodes only the low bits
    assign eff_addr = req.base + req.offset;

    assign op.done_vld   = req.valid;
    assign op.done_idx   = req.rob_idx;

    // direction from the request type
    assign op.mem_rd     = req.valid && !req.is_store;
    assign op.mem_wrt    = req.valid && req.is_store;

    assign op.phy_addr   = req.dst_preg;
    assign op.addr       = eff_addr;
    assign op.store_data = req.store_data;

endmodule

//--- logic/ex_wb_reg.sv
//////////////////////////////////////////////////////////////////////
// EX/WB pipeline register for all four units, held while stall is high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ex_wb_reg
    import exec_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         stall,
    input  unit_result_t alu1_res,
    input  unit_result_t alu2_res,
    input  unit_result_t mult_res,
    input  mem_op_t      ldst_op,
    output ex_wb_t       ex_wb
);

    ex_wb_t ex_wb_d;
    logic   load_en;

    assign load_en = !stall;

    //////////////////////////////////////////////////////////////////////
    // next word
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ex_wb_d      = ex_wb;
        if (load_en) begin
            ex_wb_d.alu1 = alu1_res;
            ex_wb_d.alu2 = alu2_res;
            ex_wb_d.mult = mult_res;
            ex_wb_d.ldst = ldst_op;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // register
    //////////////////////////////////////////////////////////////////////
    // reset leaves no done, register write or memory access pending
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_wb <= '0;
        end else begin
            ex_wb <= ex_wb_d;
        end
    end

endmodule

//--- logic/wb_stage.sv
//////////////////////////////////////////////////////////////////////
// writeback: physical register file, data memory and the done report
// four register write ports, later port wins on the same index
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_defs.svh"

module wb_stage
    import exec_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  ex_wb_t             ex_wb,
    input  logic [`PREG_W-1:0] rf_rd_addr,
    output logic [`DATA_W-1:0] rf_rd_data,
    output wb_done_t           done
);

    logic [`DATA_W-1:0]     rf [`RF_DEPTH];
    logic [`RF_DEPTH-1:0]   rf_vld;
    logic [`DATA_W-1:0]     dmem [`DMEM_DEPTH];
    logic [`DMEM_DEPTH-1:0] dmem_vld;
    logic [`DMEM_AW-1:0]    mem_addr;
    logic [`DATA_W-1:0]     ld_data;
    logic                   alu1_we;
    logic                   alu2_we;
    logic                   mult_we;
    logic                   ld_we;
    logic                   st_we;

    assign alu1_we = ex_wb.alu1.done_vld && ex_wb.alu1.reg_wrt;
    assign alu2_we = ex_wb.alu2.done_vld && ex_wb.alu2.reg_wrt;
    assign mult_we = ex_wb.mult.done_vld && ex_wb.mult.reg_wrt;
    assign ld_we   = ex_wb.ldst.done_vld && ex_wb.ldst.mem_rd;
    assign st_we   = ex_wb.ldst.done_vld && ex_wb.ldst.mem_wrt;

    //////////////////////////////////////////////////////////////////////
    // data memory
    //////////////////////////////////////////////////////////////////////
    assign mem_addr = ex_wb.ldst.addr[`DMEM_AW-1:0];
    // never-written words read as zero
    assign ld_data  = dmem_vld[mem_addr] ? dmem[mem_addr] : '0;

    always_ff @(posedge clk) begin
        if (st_we) begin
            dmem[mem_addr] <= ex_wb.ldst.store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_vld <= '0;
        end else if (st_we) begin
            dmem_vld[mem_addr] <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////////////////////////
    // priority is alu1 < alu2 < mult < load by statement order
    always_ff @(posedge clk) begin
        if (alu1_we) begin
            rf[ex_wb.alu1.phy_addr] <= ex_wb.alu1.data;
        end
        if (alu2_we) begin
            rf[ex_wb.alu2.phy_addr] <= ex_wb.alu2.data;
        end
        if (mult_we) begin
            rf[ex_wb.mult.phy_addr] <= ex_wb.mult.data;
        end
        if (ld_we) begin
            rf[ex_wb.ldst.phy_addr] <= ld_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rf_vld <= '0;
        end else begin
            if (alu1_we) begin
                rf_vld[ex_wb.alu1.phy_addr] <= 1'b1;
            end
            if (alu2_we) begin
                rf_vld[ex_wb.alu2.phy_addr] <= 1'b1;
            end
            if (mult_we) begin
                rf_vld[ex_wb.mult.phy_addr] <= 1'b1;
            end
            if (ld_we) begin
                rf_vld[ex_wb.ldst.phy_addr] <= 1'b1;
            end
        end
    end

    assign rf_rd_data = rf_vld[rf_rd_addr] ? rf[rf_rd_addr] : '0;

    // done report straight from the EX/WB word
    assign done.alu1_done_vld = ex_wb.alu1.done_vld;
    assign done.alu1_done_idx = ex_wb.alu1.done_idx;
    assign done.alu2_done_vld = ex_wb.alu2.done_vld;
    assign done.alu2_done_idx = ex_wb.alu2.done_idx;
    assign done.mult_done_vld = ex_wb.mult.done_vld;
    assign done.mult_done_idx = ex_wb.mult.done_idx;
    assign done.ldst_done_vld = ex_wb.ldst.done_vld;
    assign done.ldst_done_idx = ex_wb.ldst.done_idx;

endmodule

//--- logic/exec_core.sv
//////////////////////////////////////////////////////////////////////
// execute and writeback top level: four units, EX/WB register, writeback
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_defs.svh"

module exec_core
    import exec_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  exec_req_t          alu1_req,
    input  exec_req_t          alu2_req,
    input  exec_req_t          mult_req,
    input  mem_req_t           ldst_req,
    input  logic               stall,
    input  logic [`PREG_W-1:0] rf_rd_addr,
    output wb_done_t           done,
    output logic [`DATA_W-1:0] rf_rd_data,
    output logic               mult_idle
);

    unit_result_t alu1_res;
    unit_result_t alu2_res;
    unit_result_t mult_res;
    mem_op_t      ldst_op;
    ex_wb_t       ex_wb;

    //////////////////////////////////////////////////////////////////////
    // execution units
    //////////////////////////////////////////////////////////////////////
    alu_unit alu1 (
        .req (alu1_req),
        .res (alu1_res)
    );

    alu_unit alu2 (
        .req (alu2_req),
        .res (alu2_res)
    );

    // mult_idle goes to the issue side unregistered
    mult_unit mult (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .req       (mult_req),
        .res       (mult_res),
        .mult_idle (mult_idle)
    );

    addr_unit ldst (
        .req (ldst_req),
        .op  (ldst_op)
    );

    //////////////////////////////////////////////////////////////////////
    // EX/WB and writeback
    //////////////////////////////////////////////////////////////////////
    ex_wb_reg ex_wb0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .alu1_res (alu1_res),
        .alu2_res (alu2_res),
        .mult_res (mult_res),
        .ldst_op  (ldst_op),
        .ex_wb    (ex_wb)
    );

    wb_stage wb0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_wb      (ex_wb),
        .rf_rd_addr (rf_rd_addr),
        .rf_rd_data (rf_rd_data),
        .done       (done)
    );

endmodule

//--- verif/exec_core_assertions.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks on the execute slice, bound to exec_core
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_defs.svh"

module exec_core_assertions
    import exec_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      stall,
    input logic      mult_idle,
    input exec_req_t mult_req,
    input wb_done_t  done
);

    // nothing completes while reset is held
    assert property (@(posedge clk) !rst_n |-> (done == '0))
        else $error("done flag set during reset");

    // accepted multiply keeps the unit busy for all its steps
    assert property (@(posedge clk) disable iff (!rst_n)
        (mult_idle && mult_req.valid && !stall) |=> !mult_idle [*`MULT_STEPS])
        else $error("mult_idle high during a multiply");

    // EX/WB word frozen under stall
    assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(done))
        else $error("done changed while stalled");

endmodule

bind exec_core exec_core_assertions chk0 (.*);

//--- verif/exec_core_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for exec_core: directed and random operations against a model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "exec_defs.svh"

module exec_core_tb
    import exec_pkg::*;
;

    localparam int N_OPS   = 300;
    localparam int MAX_CYC = N_OPS * (`MULT_STEPS + 4) + 100;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic stall = 1'b0;
    exec_req_t alu1_req = '0;
    exec_req_t alu2_req = '0;
    exec_req_t mult_req = '0;
    mem_req_t ldst_req = '0;
    logic [`PREG_W-1:0] rf_rd_addr = '0;
    wb_done_t done;
    logic [`DATA_W-1:0] rf_rd_data;
    logic mult_idle;

    integer seed = 32'hba9b;
    int err_cnt = 0;
    int chk_cnt = 0;
    int cyc = 0;

    // model state
    logic [`DATA_W-1:0] m_rf [`RF_DEPTH];
    logic [`DATA_W-1:0] m_mem [`DMEM_DEPTH];
    ex_wb_t m_wb;
    unit_result_t m_mrec;
    logic m_busy;
    int m_left;

    exec_core dut0 (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > MAX_CYC) begin
            $display("timeout: run exceeded %0d cycles", MAX_CYC);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [`DATA_W-1:0] ref_result(input logic is_mult, input alu_op_e op,
            input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b);
        logic [31:0] prod;
        prod = a * b;
        if (is_mult) begin
            return prod[`DATA_W-1:0];
        end
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_shl: return a << b[3:0];
            alu_shr: return a >> b[3:0];
            default: return b;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // model update and compare, one pass per rising edge
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        ex_wb_t nxt;
        if (!rst_n) begin
            for (int i = 0; i < `RF_DEPTH; i++) m_rf[i] = '0;
            for (int i = 0; i < `DMEM_DEPTH; i++) m_mem[i] = '0;
            m_wb = '0;
            m_busy = 1'b0;
            m_left = 0;
        end else begin
            // writes of the word held before this edge, alu1 lowest
            if (m_wb.alu1.done_vld && m_wb.alu1.reg_wrt) m_rf[m_wb.alu1.phy_addr] = m_wb.alu1.data;
            if (m_wb.alu2.done_vld && m_wb.alu2.reg_wrt) m_rf[m_wb.alu2.phy_addr] = m_wb.alu2.data;
            if (m_wb.mult.done_vld && m_wb.mult.reg_wrt) m_rf[m_wb.mult.phy_addr] = m_wb.mult.data;
            if (m_wb.ldst.done_vld && m_wb.ldst.mem_wrt) begin
                m_mem[m_wb.ldst.addr[`DMEM_AW-1:0]] = m_wb.ldst.store_data;
            end
            if (m_wb.ldst.done_vld && m_wb.ldst.mem_rd) begin
                m_rf[m_wb.ldst.phy_addr] = m_mem[m_wb.ldst.addr[`DMEM_AW-1:0]];
            end
            if (!stall) begin
                nxt = '0;
                nxt.alu1 = '{alu1_req.valid, alu1_req.rob_idx, alu1_req.reg_wrt, alu1_req.dst_preg,
                    ref_result(1'b0, alu1_req.op, alu1_req.src_a, alu1_req.src_b)};
                nxt.alu2 = '{alu2_req.valid, alu2_req.rob_idx, alu2_req.reg_wrt, alu2_req.dst_preg,
                    ref_result(1'b0, alu2_req.op, alu2_req.src_a, alu2_req.src_b)};
                if (m_busy) begin
                    m_left--;
                    if (m_left == 0) begin
                        nxt.mult = m_mrec;
                        m_busy = 1'b0;
                    end
                end else if (mult_req.valid) begin
                    m_busy = 1'b1;
                    m_left = `MULT_STEPS;
                    m_mrec = '{1'b1, mult_req.rob_idx, mult_req.reg_wrt, mult_req.dst_preg,
                        ref_result(1'b1, alu_add, mult_req.src_a, mult_req.src_b)};
                end
                nxt.ldst = '{ldst_req.valid, ldst_req.rob_idx, ldst_req.valid && !ldst_req.is_store,
                    ldst_req.valid && ldst_req.is_store, ldst_req.dst_preg,
                    ldst_req.base + ldst_req.offset, ldst_req.store_data};
                m_wb = nxt;
            end
            #1;
            check_val("alu1_done_vld", done.alu1_done_vld, m_wb.alu1.done_vld);
            check_val("alu2_done_vld", done.alu2_done_vld, m_wb.alu2.done_vld);
            check_val("mult_done_vld", done.mult_done_vld, m_wb.mult.done_vld);
            check_val("ldst_done_vld", done.ldst_done_vld, m_wb.ldst.done_vld);
            if (m_wb.alu1.done_vld) check_val("alu1_done_idx", done.alu1_done_idx, m_wb.alu1.done_idx);
            if (m_wb.alu2.done_vld) check_val("alu2_done_idx", done.alu2_done_idx, m_wb.alu2.done_idx);
            if (m_wb.mult.done_vld) check_val("mult_done_idx", done.mult_done_idx, m_wb.mult.done_idx);
            if (m_wb.ldst.done_vld) check_val("ldst_done_idx", done.ldst_done_idx, m_wb.ldst.done_idx);
            check_val("mult_idle", mult_idle, !m_busy);
            check_val("rf_rd_data", rf_rd_data, m_rf[rf_rd_addr]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////
    task automatic tick();
        @(negedge clk);
    endtask

    function automatic exec_req_t make_req(input alu_op_e op, input logic [`DATA_W-1:0] a,
            input logic [`DATA_W-1:0] b, input int dst, input int rob);
        return '{1'b1, op, a, b, dst[`PREG_W-1:0], rob[`ROB_W-1:0], 1'b1};
    endfunction

    function automatic exec_req_t rand_req();
        exec_req_t r;
        r = make_req(alu_op_e'($random(seed) & 7), $random(seed), $random(seed),
            $random(seed) & 63, $random(seed) & 63);
        r.valid = $random(seed) & 1;
        return r;
    endfunction

    task automatic clear_reqs();
        alu1_req.valid = 1'b0;
        alu2_req.valid = 1'b0;
        mult_req.valid = 1'b0;
        ldst_req.valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (!mult_idle) tick();
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s: %0d errors", name, err_cnt - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed and random sequences
    //////////////////////////////////////////////////////////////////////
    task automatic reset_values();
        int e0 = err_cnt;
        rf_rd_addr = 6'd17;
        tick();
        check_val("done", done, '0);
        check_val("mult_idle", mult_idle, 1'b1);
        check_val("rf_rd_data", rf_rd_data, '0);
        report_test("reset", e0);
    endtask

    task automatic alu_ops();
        int e0 = err_cnt;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            alu1_req = make_req(alu_op_e'(i), a, b, i + 1, i);
            alu2_req = make_req(alu_op_e'(i), b, a, i + 9, i + 32);
            rf_rd_addr = i + 1;
            tick();
            clear_reqs();
            check_val("alu1_done_idx", done.alu1_done_idx, i);
            check_val("alu2_done_idx", done.alu2_done_idx, i + 32);
            tick();
            check_val("rf_rd_data", rf_rd_data, ref_result(1'b0, alu_op_e'(i), a, b));
            rf_rd_addr = i + 9;
            tick();
            check_val("rf_rd_data", rf_rd_data, ref_result(1'b0, alu_op_e'(i), b, a));
        end
        // both ALUs on one destination, alu2 wins
        alu1_req = make_req(alu_add, 16'h1111, 16'h0001, 5, 20);
        alu2_req = make_req(alu_pass_b, 16'h0, 16'hbeef, 5, 21);
        rf_rd_addr = 5;
        tick();
        clear_reqs();
        tick();
        check_val("rf_rd_data", rf_rd_data, 16'hbeef);
        report_test("alu", e0);
    endtask

    task automatic mult_latency();
        int e0 = err_cnt;
        int lat;
        for (int i = 0; i < 6; i++) begin
            wait_idle();
            mult_req = make_req(alu_add, $random(seed), $random(seed), 40 + i, 50 + i);
            rf_rd_addr = 40 + i;
            tick();
            mult_req.valid = 1'b0;
            lat = 1;
            check_val("mult_idle", mult_idle, 1'b0);
            while (!done.mult_done_vld && lat < 20) begin
                tick();
                lat++;
            end
            check_val("mult_latency", lat, `MULT_STEPS + 1);
            tick();
        end
        report_test("mult", e0);
    endtask

    task automatic store_load();
        int e0 = err_cnt;
        ldst_req = '{1'b1, 1'b1, 16'h0100, 16'h0023, 16'h5a5a, 6'd0, 6'd3};
        tick();
        ldst_req = '{1'b1, 1'b0, 16'h0020, 16'h0003, 16'h0, 6'd20, 6'd4};
        tick();
        // destination still holds the priority test result
        ldst_req = '{1'b1, 1'b0, 16'h0000, 16'h0077, 16'h0, 6'd5, 6'd5};
        rf_rd_addr = 20;
        tick();
        clear_reqs();
        check_val("rf_rd_data", rf_rd_data, 16'h5a5a);
        rf_rd_addr = 5;
        tick();
        check_val("rf_rd_data", rf_rd_data, 16'h0000);
        report_test("store_load", e0);
    endtask

    task automatic stall_hold();
        int e0 = err_cnt;
        int lat;
        logic [`DATA_W-1:0] a = $random(seed);
        logic [`DATA_W-1:0] b = $random(seed);
        wait_idle();
        mult_req = make_req(alu_add, a, b, 30, 40);
        tick();
        mult_req.valid = 1'b0;
        alu1_req = make_req(alu_xor, a, b, 31, 41);
        tick();
        alu1_req.valid = 1'b0;
        lat = 2;
        stall = 1'b1;
        repeat (3) begin
            tick();
            lat++;
            check_val("alu1_done_vld", done.alu1_done_vld, 1'b1);
            check_val("alu1_done_idx", done.alu1_done_idx, 41);
        end
        stall = 1'b0;
        while (!done.mult_done_vld && lat < 30) begin
            tick();
            lat++;
        end
        check_val("mult_latency", lat, `MULT_STEPS + 1 + 3);
        rf_rd_addr = 30;
        tick();
        check_val("rf_rd_data", rf_rd_data, ref_result(1'b1, alu_add, a, b));
        rf_rd_addr = 31;
        tick();
        check_val("rf_rd_data", rf_rd_data, a ^ b);
        report_test("stall", e0);
    endtask

    task automatic random_mix();
        int e0 = err_cnt;
        for (int n = 0; n < 200; n++) begin
            alu1_req = rand_req();
            alu2_req = rand_req();
            mult_req = rand_req();
            mult_req.valid = mult_idle && mult_req.valid;
            ldst_req = '{$random(seed), $random(seed), $random(seed), $random(seed),
                $random(seed), $random(seed), $random(seed)};
            rf_rd_addr = $random(seed);
            tick();
        end
        clear_reqs();
        wait_idle();
        repeat (2) tick();
        for (int i = 0; i < `RF_DEPTH; i++) begin
            rf_rd_addr = i;
            tick();
            check_val("rf_rd_data", rf_rd_data, m_rf[i]);
        end
        report_test("random", e0);
    endtask

    initial begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_values();
        alu_ops();
        mult_latency();
        store_load();
        stall_hold();
        random_mix();
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
logic/exec_pkg.sv
logic/alu_unit.sv
logic/mult_unit.sv
logic/addr_unit.sv
logic/ex_wb_reg.sv
logic/wb_stage.sv
logic/exec_core.sv
verif/exec_core_assertions.sv
verif/exec_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the exec_core testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module exec_core_tb -o exec_core_sim \
    && ./obj_dir/exec_core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "All checks passed" sim.log && exit 0 || exit 1
